//--- Makefile
# Verilator build and run of the pooling path testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_pool_layer
FILELIST  ?= cnn_pool_layer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_STR  ?= Test passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- cnn_pool_layer.f
+incdir+src
src/pool_pkg.sv
src/fm_ram.sv
src/max_pool_unit.sv
src/pool_scan.sv
src/layer_ctrl.sv
src/cnn_pool_layer.sv
verif/pool_checker.sv
verif/tb_cnn_pool_layer.sv

//--- src/cnn_pool_layer.sv
`include "pool_cfg.svh"

module cnn_pool_layer import pool_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  layer_type_e layer_type_i,
    input  layer_num_t  layer_num_i,
    input  size_t       fm_size_i,
    input  depth_t      fm_depth_i,
    input  fm_word_t    init_fm_data_i,
    input  fm_addr_t    write_fm_data_addr_i,
    input  logic        init_fm_data_done_i,
    input  fm_addr_t    dbg_addr_i,
    output logic        init_fm_ram_ready_o,
    output logic        layer_ready_o,
    output fm_word_t    dbg_data_o
);

    pool_cfg_t pool_cfg;
    logic      start;
    logic      in_half;
    logic      scan_done;
    fm_rd_t    scan_rd;
    fm_wr_t    scan_wr;
    fm_rd_t    ram_rd;
    fm_wr_t    ram_wr;
    fm_word_t  ram_rdata;
    pool_tag_t lane_tag;
    fm_word_t  lane_result;
    logic [`PARA_Y-1:0] lane_ready;

    assign pool_cfg   = '{size: fm_size_i, depth: fm_depth_i};
    // debug data is the shared ram read port
    assign dbg_data_o = ram_rdata;

    layer_ctrl u_layer_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .layer_type_i        (layer_type_i),
        .layer_num_i         (layer_num_i),
        .init_data_i         (init_fm_data_i),
        .init_addr_i         (write_fm_data_addr_i),
        .init_done_i         (init_fm_data_done_i),
        .scan_rd_i           (scan_rd),
        .scan_wr_i           (scan_wr),
        .scan_done_i         (scan_done),
        .dbg_addr_i          (dbg_addr_i),
        .start_o             (start),
        .in_half_o           (in_half),
        .ram_rd_o            (ram_rd),
        .ram_wr_o            (ram_wr),
        .init_fm_ram_ready_o (init_fm_ram_ready_o),
        .layer_ready_o       (layer_ready_o)
    );

    pool_scan u_pool_scan (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .cfg_i         (pool_cfg),
        .in_half_i     (in_half),
        .rd_o          (scan_rd),
        .tag_o         (lane_tag),
        .lane_ready_i  (lane_ready),
        .lane_result_i (lane_result),
        .wr_o          (scan_wr),
        .done_o        (scan_done)
    );

    fm_ram u_fm_ram (
        .clk     (clk),
        .wr_i    (ram_wr),
        .rd_i    (ram_rd),
        .rdata_o (ram_rdata)
    );

    // one lane per channel of the word, all share the tag
    for (genvar i = 0; i < `PARA_Y; i++) begin : g_lane
        max_pool_unit u_max_pool_unit (
            .clk      (clk),
            .rst      (rst),
            .tag_i    (lane_tag),
            .data_i   (ram_rdata[i]),
            .ready_o  (lane_ready[i]),
            .result_o (lane_result[i])
        );
    end

endmodule

//--- src/fm_ram.sv
`include "pool_cfg.svh"

module fm_ram import pool_pkg::*; (
    input  logic     clk,
    input  fm_wr_t   wr_i,
    input  fm_rd_t   rd_i,
    output fm_word_t rdata_o
);

    // both halves in one array, half 1 starts at FM_HALF
    localparam int DEPTH = 1 << `FM_ADDR_WIDTH;

    fm_word_t mem [0:DEPTH-1];

    // ==============================
    // write port
    // ==============================

    // init load or pool result, never both in one cycle
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // ==============================
    // read port
    // ==============================

    // registered read, data shows up one cycle after the address
    // output holds its last word while the enable is low
    always_ff @(posedge clk) begin
        if (rd_i.en) begin
            rdata_o <= mem[rd_i.addr];
        end
    end

endmodule

//--- src/layer_ctrl.sv
module layer_ctrl import pool_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  layer_type_e layer_type_i,
    input  layer_num_t  layer_num_i,
    input  fm_word_t    init_data_i,
    input  fm_addr_t    init_addr_i,
    input  logic        init_done_i,
    input  fm_rd_t      scan_rd_i,
    input  fm_wr_t      scan_wr_i,
    input  logic        scan_done_i,
    input  fm_addr_t    dbg_addr_i,
    output logic        start_o,
    output logic        in_half_o,
    output fm_rd_t      ram_rd_o,
    output fm_wr_t      ram_wr_o,
    output logic        init_fm_ram_ready_o,
    output logic        layer_ready_o
);

    // last layer number that started
    layer_num_t layer_num_q;
    // a pool layer owns the ram read port
    logic running_q;
    // half that holds the current input map
    logic half_q;

    logic init_wr_en;
    logic new_layer;

    // init data streams in until done
    assign init_wr_en = (layer_type_i == LAYER_INIT) && !init_done_i;

    // a pool layer starts only on a fresh layer number
    assign new_layer = (layer_type_i == LAYER_POOL) && init_fm_ram_ready_o
                       && (layer_num_i != layer_num_q) && !running_q;

    assign start_o   = new_layer;
    assign in_half_o = half_q;

    // ==============================
    // layer sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            layer_num_q         <= '0;
            running_q           <= 1'b0;
            half_q              <= 1'b0;
            init_fm_ram_ready_o <= 1'b0;
            layer_ready_o       <= 1'b0;
        end else begin
            // last result write seen, output half becomes input half
            if (running_q && scan_done_i) begin
                running_q     <= 1'b0;
                half_q        <= ~half_q;
                layer_ready_o <= 1'b1;
            end
            case (layer_type_i)
                LAYER_INIT: begin
                    // ready follows done, layer ready one cycle later
                    init_fm_ram_ready_o <= init_done_i;
                    layer_ready_o       <= init_fm_ram_ready_o;
                    half_q              <= 1'b0;
                    running_q           <= 1'b0;
                end
                LAYER_POOL: begin
                    if (new_layer) begin
                        layer_num_q   <= layer_num_i;
                        running_q     <= 1'b1;
                        layer_ready_o <= 1'b0;
                    end
                end
                LAYER_FINISH: begin
                    // stop, half stays where it is
                    layer_ready_o <= 1'b0;
                    running_q     <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // ==============================
    // ram port selection
    // ==============================
    always_comb begin
        ram_wr_o = scan_wr_i;
        if (init_wr_en) begin
            ram_wr_o = '{en: 1'b1, addr: init_addr_i, data: init_data_i};
        end
    end

    // debug reads whenever no pool layer is running
    always_comb begin
        ram_rd_o = '{en: 1'b1, addr: dbg_addr_i};
        if (running_q) begin
            ram_rd_o = scan_rd_i;
        end
    end

endmodule

//--- src/max_pool_unit.sv
`include "pool_cfg.svh"

module max_pool_unit import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pool_tag_t tag_i,
    input  fp16_t     data_i,
    output logic      ready_o,
    output fp16_t     result_o
);

    localparam int SIGN = `DATA_WIDTH - 1;

    // running maximum of the current window
    fp16_t run_max_q;
    fp16_t next_max;

    // a > b in float16 order
    // sign-magnitude compare, +0 and -0 count as equal
    function automatic logic fp16_gt(input fp16_t a, input fp16_t b);
        logic a_zero;
        logic b_zero;
        logic gt;
        a_zero = (a[SIGN-1:0] == '0);
        b_zero = (b[SIGN-1:0] == '0);
        if (a_zero && b_zero) begin
            gt = 1'b0;
        end else if (a[SIGN] != b[SIGN]) begin
            // mixed signs, the positive one wins
            gt = !a[SIGN];
        end else if (!a[SIGN]) begin
            gt = a[SIGN-1:0] > b[SIGN-1:0];
        end else begin
            // both negative, smaller magnitude is larger
            gt = a[SIGN-1:0] < b[SIGN-1:0];
        end
        return gt;
    endfunction

    // first value of a window always loads
    assign next_max = (tag_i.first || fp16_gt(data_i, run_max_q)) ? data_i : run_max_q;

    always_ff @(posedge clk) begin
        if (tag_i.valid) begin
            run_max_q <= next_max;
            // result holds until the next window closes
            if (tag_i.last) begin
                result_o <= next_max;
            end
        end
    end

    // one-cycle pulse after the last value of a window
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= tag_i.valid && tag_i.last;
        end
    end

endmodule

//--- src/pool_cfg.svh
`ifndef POOL_CFG_SVH
`define POOL_CFG_SVH

// ==============================
// datapath widths
// ==============================

// one float16 value
`define DATA_WIDTH 16

// max-pool lanes, also the channels held in one ram word
`define PARA_Y 4

// side length of the square pooling window, stride equals window
`define POOL_WIN 2

// ==============================
// feature map ram
// ==============================

// word address width, the ram holds two halves
`define FM_ADDR_WIDTH 10
// base address of half 1
`define FM_HALF 512

// ==============================
// layer configuration
// ==============================
`define FM_SIZE_WIDTH 5
`define DEPTH_WIDTH 3
`define LAYER_NUM_WIDTH 4

`endif

//--- src/pool_pkg.sv
`include "pool_cfg.svh"

package pool_pkg;

    // ==============================
    // scalar types
    // ==============================

    // one float16 value, sign in the top bit
    typedef logic [`DATA_WIDTH-1:0] fp16_t;

    // one ram word, lane i holds channel i of the slice
    typedef fp16_t [`PARA_Y-1:0] fm_word_t;

    typedef logic [`FM_ADDR_WIDTH-1:0] fm_addr_t;
    typedef logic [`FM_SIZE_WIDTH-1:0] size_t;
    typedef logic [`DEPTH_WIDTH-1:0] depth_t;
    typedef logic [`LAYER_NUM_WIDTH-1:0] layer_num_t;

    // layer type code, any other value leaves the engine idle
    typedef enum logic [3:0] {
        LAYER_INIT   = 4'd0,
        LAYER_POOL   = 4'd2,
        LAYER_FINISH = 4'd9
    } layer_type_e;

    // ==============================
    // grouped signals
    // ==============================

    // input side length and slice count of a pool layer
    typedef struct packed {
        size_t  size;
        depth_t depth;
    } pool_cfg_t;

    // ram write port
    typedef struct packed {
        logic     en;
        fm_addr_t addr;
        fm_word_t data;
    } fm_wr_t;

    // ram read port
    typedef struct packed {
        logic     en;
        fm_addr_t addr;
    } fm_rd_t;

    // marks lane input values, first and last bound a window
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } pool_tag_t;

endpackage

//--- src/pool_scan.sv
`include "pool_cfg.svh"

module pool_scan import pool_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  pool_cfg_t         cfg_i,
    input  logic              in_half_i,
    output fm_rd_t            rd_o,
    output pool_tag_t         tag_o,
    input  logic [`PARA_Y-1:0] lane_ready_i,
    input  fm_word_t          lane_result_i,
    output fm_wr_t            wr_o,
    output logic              done_o
);

    localparam int WIN_W = $clog2(`POOL_WIN);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`POOL_WIN - 1);
    // wide enough for depth * osize * osize
    localparam int CNT_W = `DEPTH_WIDTH + 2 * `FM_SIZE_WIDTH;

    // layer config, latched on start
    size_t    size_q;
    size_t    osize_q;
    depth_t   depth_q;
    fm_addr_t plane_q;
    logic     in_half_q;

    // read side, one address per cycle while busy
    logic             busy_q;
    depth_t           slice_q;
    size_t            row_q;
    size_t            col_q;
    logic [WIN_W-1:0] win_r_q;
    logic [WIN_W-1:0] win_c_q;

    // write side
    fm_addr_t         out_idx_q;
    logic [CNT_W-1:0] remain_q;
    logic             empty_q;
    pool_tag_t        tag_q;

    size_t            start_osize;
    logic [CNT_W-1:0] start_total;
    size_t            rd_row;
    size_t            rd_col;
    fm_addr_t         in_base;
    fm_addr_t         out_base;
    pool_tag_t        tag_d;

    // odd last row and column drop out of the floor
    assign start_osize = size_t'(cfg_i.size / `POOL_WIN);
    assign start_total = cfg_i.depth * start_osize * start_osize;

    // ==============================
    // read address generation
    // ==============================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q    <= 1'b0;
            slice_q   <= '0;
            row_q     <= '0;
            col_q     <= '0;
            win_r_q   <= '0;
            win_c_q   <= '0;
            size_q    <= '0;
            osize_q   <= '0;
            depth_q   <= '0;
            plane_q   <= '0;
            in_half_q <= 1'b0;
        end else if (start_i) begin
            // an empty layer never goes busy
            busy_q    <= (start_total != '0);
            slice_q   <= '0;
            row_q     <= '0;
            col_q     <= '0;
            win_r_q   <= '0;
            win_c_q   <= '0;
            size_q    <= cfg_i.size;
            osize_q   <= start_osize;
            depth_q   <= cfg_i.depth;
            plane_q   <= cfg_i.size * cfg_i.size;
            in_half_q <= in_half_i;
        end else if (busy_q) begin
            // window column fastest, then window row, col, row, slice
            if (win_c_q != WIN_LAST) begin
                win_c_q <= win_c_q + 1'b1;
            end else begin
                win_c_q <= '0;
                if (win_r_q != WIN_LAST) begin
                    win_r_q <= win_r_q + 1'b1;
                end else begin
                    win_r_q <= '0;
                    if (col_q != osize_q - 1'b1) begin
                        col_q <= col_q + 1'b1;
                    end else begin
                        col_q <= '0;
                        if (row_q != osize_q - 1'b1) begin
                            row_q <= row_q + 1'b1;
                        end else begin
                            row_q <= '0;
                            if (slice_q != depth_q - 1'b1) begin
                                slice_q <= slice_q + 1'b1;
                            end else begin
                                busy_q <= 1'b0;
                            end
                        end
                    end
                end
            end
        end
    end

    assign in_base  = in_half_q ? fm_addr_t'(`FM_HALF) : '0;
    assign out_base = in_half_q ? '0 : fm_addr_t'(`FM_HALF);

    // input pixel of the current window phase
    assign rd_row = size_t'(row_q * `POOL_WIN + win_r_q);
    assign rd_col = size_t'(col_q * `POOL_WIN + win_c_q);

    // base + slice * side^2 + row * side + col
    assign rd_o = '{
        en:   busy_q,
        addr: in_base + fm_addr_t'(slice_q) * plane_q
              + fm_addr_t'(rd_row) * fm_addr_t'(size_q) + fm_addr_t'(rd_col)
    };

    assign tag_d = '{
        valid: busy_q,
        first: busy_q && (win_r_q == '0) && (win_c_q == '0),
        last:  busy_q && (win_r_q == WIN_LAST) && (win_c_q == WIN_LAST)
    };

    // ==============================
    // tag delay and result writes
    // ==============================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_q     <= '0;
            out_idx_q <= '0;
            remain_q  <= '0;
            empty_q   <= 1'b0;
        end else begin
            // match the registered ram read
            tag_q   <= tag_d;
            empty_q <= start_i && (start_total == '0);
            if (start_i) begin
                out_idx_q <= '0;
                remain_q  <= start_total;
            end else if (wr_o.en) begin
                out_idx_q <= out_idx_q + 1'b1;
                remain_q  <= remain_q - 1'b1;
            end
        end
    end

    assign tag_o = tag_q;

    // all lanes close their window in the same cycle
    assign wr_o = '{
        en:   &lane_ready_i,
        addr: out_base + out_idx_q,
        data: lane_result_i
    };

    assign done_o = (wr_o.en && (remain_q == CNT_W'(1))) || empty_q;

endmodule

//--- verif/pool_checker.sv
`include "pool_cfg.svh"

module pool_checker import pool_pkg::*; (
    input logic        clk,
    input logic        rst,
    input layer_type_e layer_type_i,
    input layer_num_t  layer_num_i,
    input size_t       fm_size_i,
    input depth_t      fm_depth_i,
    input fm_word_t    init_fm_data_i,
    input fm_addr_t    write_fm_data_addr_i,
    input logic        init_fm_data_done_i,
    input fm_addr_t    dbg_addr_i,
    input logic        init_ready_i,
    input logic        layer_ready_i,
    input fm_word_t    dbg_data_i
);

    localparam int WORDS = 1 << `FM_ADDR_WIDTH;

    // name of the running test as set by the testbench top
    string test_name = "reset";
    int    err_cnt   = 0;
    int    chk_cnt   = 0;

    // shadow ram and a flag per word that holds a defined value
    fm_word_t shadow [0:WORDS-1];
    bit       known  [0:WORDS-1];

    // layer state rebuilt from the ports
    logic        busy;
    logic        half;
    layer_num_t  last_num;
    size_t       pool_side;
    depth_t      pool_depth;
    logic        pend_valid;
    fm_addr_t    pend_addr;
    layer_type_e prev_type;
    logic        prev_done;
    logic        prev_lr;
    // expected init_fm_ram_ready_o from the done input
    logic        init_ready_exp;
    // layer ready must be low one edge after a pool start
    logic        drop_due;

    // float16 order as a signed key where both zeros give 0
    function automatic int fp16_key(input fp16_t v);
        int mag;
        mag = int'(v[`DATA_WIDTH-2:0]);
        return v[`DATA_WIDTH-1] ? -mag : mag;
    endfunction

    // ==============================
    // reference max pool
    // ==============================

    // window reads in row-major order
    // a later value wins only when strictly greater
    function automatic void pool_model(input int side, input int depth, input logic in_half);
        int       os;
        int       ib;
        int       ob;
        fm_addr_t a;
        fm_word_t best;
        os = side / `POOL_WIN;
        ib = in_half ? `FM_HALF : 0;
        ob = in_half ? 0 : `FM_HALF;
        for (int s = 0; s < depth; s++) begin
            for (int r = 0; r < os; r++) begin
                for (int c = 0; c < os; c++) begin
                    for (int p = 0; p < `POOL_WIN * `POOL_WIN; p++) begin
                        a = fm_addr_t'(ib + s * side * side
                                       + (r * `POOL_WIN + p / `POOL_WIN) * side
                                       + c * `POOL_WIN + p % `POOL_WIN);
                        for (int l = 0; l < `PARA_Y; l++) begin
                            if (p == 0 || fp16_key(shadow[a][l]) > fp16_key(best[l])) begin
                                best[l] = shadow[a][l];
                            end
                        end
                    end
                    // output map uses the same layout with the halved side
                    a = fm_addr_t'(ob + (s * os + r) * os + c);
                    shadow[a] = best;
                    known[a]  = 1'b1;
                end
            end
        end
    endfunction

    task automatic report(input string what);
        err_cnt++;
        $display("%s: %s", test_name, what);
    endtask

    // ==============================
    // port monitor
    // ==============================

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            busy           = 1'b0;
            half           = 1'b0;
            last_num       = '0;
            pool_side      = '0;
            pool_depth     = '0;
            pend_valid     = 1'b0;
            pend_addr      = '0;
            prev_type      = layer_type_e'(4'hf);
            prev_done      = 1'b0;
            prev_lr        = 1'b0;
            init_ready_exp = 1'b0;
            drop_due       = 1'b0;
        end else begin
            // debug word read at the last edge
            if (pend_valid && known[pend_addr]) begin
                chk_cnt++;
                if (dbg_data_i !== shadow[pend_addr]) begin
                    err_cnt++;
                    $display("** Error [%s] addr %0d expected %h actual %h",
                             test_name, pend_addr, shadow[pend_addr], dbg_data_i);
                end
            end
            // ready follows done by one cycle and layer ready follows ready
            if (prev_type == LAYER_INIT) begin
                chk_cnt++;
                if (layer_ready_i !== init_ready_exp) begin
                    report("layer_ready_o did not follow init_fm_ram_ready_o by one cycle");
                end
                init_ready_exp = prev_done;
                if (init_ready_i !== init_ready_exp) begin
                    report("init_fm_ram_ready_o did not follow the done input by one cycle");
                end
            end
            // a started pool layer drops layer ready at the next edge
            if (drop_due) begin
                chk_cnt++;
                if (layer_ready_i !== 1'b0) begin
                    report("layer_ready_o stayed high after a pool layer started");
                end
            end
            drop_due = 1'b0;
            // no fresh layer number means no drop of layer ready
            if (!busy && prev_type == LAYER_POOL && prev_lr && !layer_ready_i) begin
                report("layer_ready_o dropped without a new layer number");
            end
            if (prev_type == LAYER_FINISH && layer_ready_i) begin
                report("layer_ready_o is high during a finish layer");
            end
            // output half turns into input half when a pool layer ends
            if (busy && layer_ready_i && !prev_lr) begin
                pool_model(int'(pool_side), int'(pool_depth), half);
                half = !half;
                busy = 1'b0;
            end
            if (layer_type_i == LAYER_INIT) begin
                half = 1'b0;
                busy = 1'b0;
                if (!init_fm_data_done_i) begin
                    shadow[write_fm_data_addr_i] = init_fm_data_i;
                    known[write_fm_data_addr_i]  = 1'b1;
                end
            end
            if (layer_type_i == LAYER_FINISH) begin
                busy = 1'b0;
            end
            // the ram read port belongs to debug unless a pool runs
            pend_valid = !busy && !(layer_type_i == LAYER_INIT && !init_fm_data_done_i);
            pend_addr  = dbg_addr_i;
            if (!busy && layer_type_i == LAYER_POOL && init_ready_exp
                    && layer_num_i != last_num) begin
                busy       = 1'b1;
                drop_due   = 1'b1;
                last_num   = layer_num_i;
                pool_side  = fm_size_i;
                pool_depth = fm_depth_i;
            end
            prev_type = layer_type_i;
            prev_done = init_fm_data_done_i;
            prev_lr   = layer_ready_i;
        end
    end

endmodule

//--- verif/tb_cnn_pool_layer.sv
`include "pool_cfg.svh"

module tb_cnn_pool_layer import pool_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int SEED       = 32;
    localparam int HOLD       = 20;
    localparam int MAP_SIDE   = 8;
    localparam int ODD_SIDE   = 7;
    localparam int MAP_DEPTH  = 2;

    logic        clk;
    logic        rst;
    layer_type_e layer_type;
    layer_num_t  layer_num;
    size_t       fm_size;
    depth_t      fm_depth;
    fm_word_t    init_data;
    fm_addr_t    init_addr;
    logic        init_done;
    fm_addr_t    dbg_addr;
    logic        init_ready;
    logic        layer_ready;
    fm_word_t    dbg_data;

    int tests_run = 0;
    int tests_bad = 0;
    int err_start = 0;
    int chk_start = 0;

    cnn_pool_layer u_cnn_pool_layer (
        .clk                  (clk),
        .rst                  (rst),
        .layer_type_i         (layer_type),
        .layer_num_i          (layer_num),
        .fm_size_i            (fm_size),
        .fm_depth_i           (fm_depth),
        .init_fm_data_i       (init_data),
        .write_fm_data_addr_i (init_addr),
        .init_fm_data_done_i  (init_done),
        .dbg_addr_i           (dbg_addr),
        .init_fm_ram_ready_o  (init_ready),
        .layer_ready_o        (layer_ready),
        .dbg_data_o           (dbg_data)
    );

    pool_checker u_pool_checker (
        .clk                  (clk),
        .rst                  (rst),
        .layer_type_i         (layer_type),
        .layer_num_i          (layer_num),
        .fm_size_i            (fm_size),
        .fm_depth_i           (fm_depth),
        .init_fm_data_i       (init_data),
        .write_fm_data_addr_i (init_addr),
        .init_fm_data_done_i  (init_done),
        .dbg_addr_i           (dbg_addr),
        .init_ready_i         (init_ready),
        .layer_ready_i        (layer_ready),
        .dbg_data_i           (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // cycle budgets
    // ==============================
    function automatic int out_words(input int side, input int depth);
        return depth * (side / `POOL_WIN) * (side / `POOL_WIN);
    endfunction

    function automatic int init_len(input int side, input int depth);
        return side * side * depth + 8;
    endfunction

    // one read per window value plus the pipeline tail
    function automatic int pool_len(input int side, input int depth);
        return `POOL_WIN * `POOL_WIN * out_words(side, depth) + 12;
    endfunction

    // random float16, exponent never all ones
    function automatic fp16_t rand_fp16();
        fp16_t v;
        v[15]    = 1'($urandom);
        v[14:10] = 5'($urandom_range(30, 0));
        v[9:0]   = 10'($urandom);
        return v;
    endfunction

    // ==============================
    // stimulus tasks
    // ==============================
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_layer_ready(input int limit);
        int n;
        n = 0;
        next_cycle();
        while (!layer_ready && n < limit) begin
            next_cycle();
            n++;
        end
        if (!layer_ready) begin
            $display("%s: layer_ready_o did not rise within %0d cycles",
                     u_pool_checker.test_name, limit);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic load_map(input int side, input int depth);
        fm_word_t w;
        next_cycle();
        layer_type = LAYER_INIT;
        init_done  = 1'b0;
        for (int s = 0; s < depth; s++) begin
            for (int r = 0; r < side; r++) begin
                for (int c = 0; c < side; c++) begin
                    for (int l = 0; l < `PARA_Y; l++) begin
                        w[l] = rand_fp16();
                    end
                    // first window of slice 0 holds zero ties and negative-only lanes
                    if (s == 0 && r < 2 && c < 2) begin
                        w[0]     = ((r + c) % 2 == 0) ? 16'h8000 : 16'h0000;
                        w[2]     = ((r + c) % 2 == 0) ? 16'h0000 : 16'h8000;
                        w[1][15] = 1'b1;
                        w[3][15] = 1'b1;
                    end
                    // odd edge row and column get the largest finite value
                    if (side % 2 == 1 && (r == side - 1 || c == side - 1)) begin
                        w = {`PARA_Y{16'h7bff}};
                    end
                    init_addr = fm_addr_t'(s * side * side + r * side + c);
                    init_data = w;
                    next_cycle();
                end
            end
        end
        init_done = 1'b1;
        wait_layer_ready(init_len(side, depth));
    endtask

    task automatic run_pool(input int num, input int side, input int depth);
        layer_type = LAYER_POOL;
        layer_num  = layer_num_t'(num);
        fm_size    = size_t'(side);
        fm_depth   = depth_t'(depth);
        wait_layer_ready(pool_len(side, depth));
    endtask

    // one address per cycle, the checker compares the word a cycle later
    task automatic read_back(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            dbg_addr = fm_addr_t'(base + i);
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic begin_test(input string name);
        u_pool_checker.test_name = name;
        err_start = u_pool_checker.err_cnt;
        chk_start = u_pool_checker.chk_cnt;
    endtask

    task automatic end_test();
        int errs;
        errs = u_pool_checker.err_cnt - err_start;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("test %s: %0d checks, %0d errors", u_pool_checker.test_name,
                 u_pool_checker.chk_cnt - chk_start, errs);
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        void'($urandom(SEED));
        rst        = 1'b0;
        layer_type = layer_type_e'(4'hf);
        layer_num  = '0;
        fm_size    = '0;
        fm_depth   = '0;
        init_data  = '0;
        init_addr  = '0;
        init_done  = 1'b0;
        dbg_addr   = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;

        begin_test("init_load");
        load_map(MAP_SIDE, MAP_DEPTH);
        read_back(0, MAP_SIDE * MAP_SIDE * MAP_DEPTH);
        end_test();

        begin_test("pool_8x8");
        run_pool(1, MAP_SIDE, MAP_DEPTH);
        read_back(`FM_HALF, out_words(MAP_SIDE, MAP_DEPTH));
        end_test();

        // second layer reads half 1 back into half 0
        begin_test("chain_swap");
        run_pool(2, MAP_SIDE / 2, MAP_DEPTH);
        read_back(0, out_words(MAP_SIDE / 2, MAP_DEPTH));
        end_test();

        begin_test("odd_side");
        load_map(ODD_SIDE, MAP_DEPTH);
        run_pool(3, ODD_SIDE, MAP_DEPTH);
        read_back(`FM_HALF, out_words(ODD_SIDE, MAP_DEPTH));
        end_test();

        // same number again, nothing may run
        begin_test("repeat_num");
        repeat (HOLD) next_cycle();
        read_back(`FM_HALF, out_words(ODD_SIDE, MAP_DEPTH));
        read_back(0, ODD_SIDE * ODD_SIDE * MAP_DEPTH);
        end_test();

        begin_test("finish");
        layer_type = LAYER_FINISH;
        repeat (HOLD) next_cycle();
        read_back(`FM_HALF, out_words(ODD_SIDE, MAP_DEPTH));
        end_test();

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, u_pool_checker.chk_cnt, u_pool_checker.err_cnt);
        if (u_pool_checker.err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the test lengths
    initial begin
        int limit;
        limit = init_len(MAP_SIDE, MAP_DEPTH) + MAP_SIDE * MAP_SIDE * MAP_DEPTH
                + pool_len(MAP_SIDE, MAP_DEPTH) + pool_len(MAP_SIDE / 2, MAP_DEPTH)
                + init_len(ODD_SIDE, MAP_DEPTH) + pool_len(ODD_SIDE, MAP_DEPTH)
                + 2 * HOLD + ODD_SIDE * ODD_SIDE * MAP_DEPTH
                + 3 * out_words(ODD_SIDE, MAP_DEPTH) + 3 * out_words(MAP_SIDE, MAP_DEPTH)
                + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule
